// ==== tb.f ====
rtl/io_bus_pkg.sv
rtl/perf_pkg.sv
rtl/performance_counters.sv
rtl/cycle_timer.sv
rtl/io_read_mux.sv
rtl/perf_subsystem.sv
tb/perf_subsystem_sva.sv
tb/tb_perf_subsystem.sv

// ==== tb/tb_perf_subsystem.sv ====
// ==================================================
// Testbench for the performance monitor subsystem
// Read results are sampled at the falling edge after the read
// Events must be idle whenever counts are read back
// ==================================================
`timescale 1ns/1ps

module tb_perf_subsystem;

	localparam io_bus_pkg::io_addr_t PERF_BASE = perf_pkg::PERF_BASE_DEFAULT;
	localparam io_bus_pkg::io_addr_t TIMER_BASE = perf_pkg::TIMER_BASE_DEFAULT;
	localparam int NUM_EVENTS = perf_pkg::MAX_EVENTS;
	localparam int NUM_COUNTERS = 4;
	localparam int MAX_BURST = 8;

	// Counts start one word per counter above the selectors
	localparam io_bus_pkg::io_addr_t COUNT_BASE = PERF_BASE + 32'(NUM_COUNTERS * 4);

	logic clk = 1'b0;
	logic reset;
	logic [NUM_EVENTS-1:0] perf_events;
	io_bus_pkg::io_addr_t io_address;
	logic io_read_en;
	logic io_write_en;
	io_bus_pkg::io_data_t io_write_data;
	io_bus_pkg::io_data_t io_read_data;

	// Model of the counters and their selectors
	io_bus_pkg::io_data_t model_count [NUM_COUNTERS];
	int model_sel [NUM_COUNTERS];

	logic [31:0] lcg_state;

	// Addresses and results of one burst of reads
	io_bus_pkg::io_addr_t burst_addr [MAX_BURST];
	io_bus_pkg::io_data_t burst_data [MAX_BURST];

	int check_count;
	int error_count;
	int test_count;
	int test_errors;
	int sva_errors;

	perf_subsystem #(
		.PERF_BASE(PERF_BASE),
		.TIMER_BASE(TIMER_BASE),
		.NUM_EVENTS(NUM_EVENTS),
		.NUM_COUNTERS(NUM_COUNTERS)
	) i_perf_subsystem (
		.clk(clk),
		.reset(reset),
		.perf_events(perf_events),
		.io_address(io_address),
		.io_read_en(io_read_en),
		.io_write_en(io_write_en),
		.io_write_data(io_write_data),
		.io_read_data(io_read_data)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// One bus cycle with an event pattern and an optional write
	// The pattern is sampled at the next edge, with the selectors in use before it
	task automatic bus_step(input logic [NUM_EVENTS-1:0] events, input logic write,
		input io_bus_pkg::io_addr_t address, input io_bus_pkg::io_data_t data);
		@(posedge clk);
		perf_events <= events;
		io_read_en <= 1'b0;
		io_write_en <= write;
		io_address <= address;
		io_write_data <= data;
		for (int i = 0; i < NUM_COUNTERS; i++)
		begin
			if (events[model_sel[i]])
				model_count[i] = model_count[i] + 32'd1;
			if (write && address == PERF_BASE + 32'(4 * i))
				model_sel[i] = int'(data[3:0]);
		end
	endtask

	task automatic random_steps(input int cycles);
		for (int n = 0; n < cycles; n++)
		begin
			lcg_state = lcg_next(lcg_state);
			bus_step(lcg_state[31:16], 1'b0, '0, '0);
		end
	endtask

	task automatic idle_steps(input int cycles);
		for (int n = 0; n < cycles; n++)
			bus_step('0, 1'b0, '0, '0);
	endtask

	// Reads on consecutive edges
	// Each result is taken in the cycle after its own read
	task automatic read_burst(input int len);
		for (int i = 0; i <= len; i++)
		begin
			@(posedge clk);
			io_write_en <= 1'b0;
			if (i < len)
			begin
				io_address <= burst_addr[i];
				io_read_en <= 1'b1;
			end
			else
				io_read_en <= 1'b0;
			if (i > 0)
			begin
				@(negedge clk);
				burst_data[i - 1] = io_read_data;
			end
		end
	endtask

	task automatic check_word(input string name, input io_bus_pkg::io_data_t expected,
		input io_bus_pkg::io_data_t actual);
		check_count++;
		assert (actual === expected)
		else
		begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	// Reads all counts back to back and compares them with the model
	task automatic check_counts(input string name);
		for (int i = 0; i < NUM_COUNTERS; i++)
			burst_addr[i] = COUNT_BASE + 32'(4 * i);
		read_burst(NUM_COUNTERS);
		for (int i = 0; i < NUM_COUNTERS; i++)
			check_word(name, model_count[i], burst_data[i]);
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (test_errors == 0)
			$display("Test %s finished with no mismatches", name);
		else
			$display("Test %s finished with %0d mismatches", name, test_errors);
		test_errors = 0;
	endtask

	// Read data has to come out of reset as a known zero
	task automatic wait_read_idle(input int limit);
		int cycles;
		cycles = 0;
		while (io_read_data !== '0 && cycles < limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (io_read_data !== '0)
		begin
			$display("Read data did not settle to zero within %0d cycles of reset", limit);
			error_count++;
		end
	endtask

	initial
	begin
		reset = 1'b1;
		perf_events = '0;
		io_address = '0;
		io_read_en = 1'b0;
		io_write_en = 1'b0;
		io_write_data = '0;
		lcg_state = 32'h77182288;
		check_count = 0;
		error_count = 0;
		test_count = 0;
		test_errors = 0;
		for (int i = 0; i < NUM_COUNTERS; i++)
		begin
			model_count[i] = '0;
			model_sel[i] = 0;
		end
		for (int i = 0; i < 4; i++)
			@(posedge clk);
		reset <= 1'b0;
		wait_read_idle(10);

		// All counts and the high-word snapshot start at zero
		check_counts("reset_state");
		burst_addr[0] = TIMER_BASE + 32'd4;
		read_burst(1);
		check_word("reset_state", '0, burst_data[0]);
		end_test("reset_state");

		// Counter i watches event 4*i+1
		for (int i = 0; i < NUM_COUNTERS; i++)
			bus_step('0, 1'b1, PERF_BASE + 32'(4 * i), 32'(4 * i + 1));
		random_steps(200);
		idle_steps(1);
		check_counts("event_counting");
		end_test("event_counting");

		// Counter 2 moves to event 3 halfway through
		random_steps(100);
		lcg_state = lcg_next(lcg_state);
		bus_step(lcg_state[31:16], 1'b1, PERF_BASE + 32'd8, 32'd3);
		random_steps(100);
		idle_steps(1);
		check_counts("reselection");
		end_test("reselection");

		// A read sampled k edges after the clear edge returns k-1
		bus_step('0, 1'b1, TIMER_BASE, '0);
		idle_steps(25);
		burst_addr[0] = TIMER_BASE;
		burst_addr[1] = TIMER_BASE;
		burst_addr[2] = TIMER_BASE + 32'd4;
		read_burst(3);
		check_word("timer_read_clear", 32'd25, burst_data[0]);
		check_word("timer_read_clear", 32'd26, burst_data[1]);
		check_word("timer_read_clear", 32'd0, burst_data[2]);
		end_test("timer_read_clear");

		// Selector words, a misaligned count address and addresses outside both blocks
		for (int i = 0; i < NUM_COUNTERS; i++)
			burst_addr[i] = PERF_BASE + 32'(4 * i);
		burst_addr[4] = 32'h0;
		burst_addr[5] = COUNT_BASE + 32'd2;
		burst_addr[6] = TIMER_BASE + 32'd8;
		burst_addr[7] = 32'h300;
		read_burst(8);
		for (int i = 0; i < 8; i++)
			check_word("unmapped_reads", '0, burst_data[i]);
		end_test("unmapped_reads");

		// The timer is cleared just before, so its low word reads as its burst position
		bus_step('0, 1'b1, TIMER_BASE, '0);
		for (int i = 0; i < NUM_COUNTERS; i++)
			burst_addr[i] = COUNT_BASE + 32'(4 * i);
		burst_addr[4] = TIMER_BASE;
		burst_addr[5] = TIMER_BASE + 32'd4;
		read_burst(6);
		for (int i = 0; i < NUM_COUNTERS; i++)
			check_word("back_to_back", model_count[i], burst_data[i]);
		check_word("back_to_back", 32'd4, burst_data[4]);
		check_word("back_to_back", 32'd0, burst_data[5]);
		end_test("back_to_back");

		// Lets the last read's assertions complete
		idle_steps(2);
		sva_errors = i_perf_subsystem.i_perf_subsystem_sva.error_count;
		$display("Tests %0d, checks %0d, mismatches %0d, assertion failures %0d",
			test_count, check_count, error_count, sva_errors);
		if (error_count == 0 && sva_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== tb/perf_subsystem_sva.sv ====
// ==================================================
// Read-data assertions bound into perf_subsystem
// Assumes read and write strobes are never high together
// Low-word order check stops when the 32-bit low word wraps
// ==================================================
`timescale 1ns/1ps

module perf_subsystem_sva
#(
	parameter io_bus_pkg::io_addr_t PERF_BASE = perf_pkg::PERF_BASE_DEFAULT,
	parameter io_bus_pkg::io_addr_t TIMER_BASE = perf_pkg::TIMER_BASE_DEFAULT,
	parameter int NUM_COUNTERS = 4
)
(
	input logic clk,
	input logic reset,
	input io_bus_pkg::io_addr_t io_address,
	input logic io_read_en,
	input logic io_write_en,
	input io_bus_pkg::io_data_t io_read_data
);

	// Count words sit just above one selector word per counter
	localparam io_bus_pkg::io_addr_t COUNT_LO = PERF_BASE + 32'(NUM_COUNTERS * 4);
	localparam io_bus_pkg::io_addr_t COUNT_HI = COUNT_LO + 32'(NUM_COUNTERS * 4);

	// Failures seen so far, read by the testbench at the end of the run
	int error_count = 0;

	logic mapped;
	logic timer_clear;
	logic low_read_q;
	logic have_prev;
	io_bus_pkg::io_data_t prev_low;

	// The six readable words of the register map
	assign mapped = io_address[1:0] == 2'b00
		&& ((io_address >= COUNT_LO && io_address < COUNT_HI)
		|| io_address == TIMER_BASE
		|| io_address == TIMER_BASE + 32'd4);

	assign timer_clear = io_write_en && io_address == TIMER_BASE;

	// Marks the cycle in which a low-word read result is on io_read_data
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			low_read_q <= 1'b0;
		else
			low_read_q <= io_read_en && io_address == TIMER_BASE && !timer_clear;
	end

	// Last low word returned since the most recent clear
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			have_prev <= 1'b0;
			prev_low <= '0;
		end
		else if (timer_clear)
			have_prev <= 1'b0;
		else if (low_read_q)
		begin
			have_prev <= 1'b1;
			prev_low <= io_read_data;
		end
	end

	unmapped_read_zero: assert property (@(posedge clk) disable iff (reset)
		io_read_en && !mapped |=> io_read_data == '0)
	else
	begin
		$error("Read of an unmapped address returned nonzero data");
		error_count++;
	end

	read_data_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(io_read_data))
	else
	begin
		$error("Read data has unknown bits");
		error_count++;
	end

	// Without a clear in between, the timer only moves forward
	low_word_increasing: assert property (@(posedge clk) disable iff (reset)
		low_read_q && have_prev |-> io_read_data > prev_low)
	else
	begin
		$error("Timer low word did not increase between two reads");
		error_count++;
	end

endmodule

bind perf_subsystem perf_subsystem_sva #(
	.PERF_BASE(PERF_BASE),
	.TIMER_BASE(TIMER_BASE),
	.NUM_COUNTERS(NUM_COUNTERS)
) i_perf_subsystem_sva (
	.clk(clk),
	.reset(reset),
	.io_address(io_address),
	.io_read_en(io_read_en),
	.io_write_en(io_write_en),
	.io_read_data(io_read_data)
);

// ==== rtl/perf_subsystem.sv ====
// ==================================================
// Performance monitor top level on the IO bus
// Read data is valid exactly one cycle after the read strobe
// Events must be synchronous to clk
// ==================================================
`timescale 1ns/1ps

module perf_subsystem
#(
	parameter io_bus_pkg::io_addr_t PERF_BASE = perf_pkg::PERF_BASE_DEFAULT,
	parameter io_bus_pkg::io_addr_t TIMER_BASE = perf_pkg::TIMER_BASE_DEFAULT,
	parameter int NUM_EVENTS = perf_pkg::MAX_EVENTS,
	parameter int NUM_COUNTERS = 4
)
(
	input  logic clk,
	input  logic reset,

	// One level strobe per event source
	input  logic [NUM_EVENTS-1:0] perf_events,

	// IO bus
	input  io_bus_pkg::io_addr_t io_address,
	input  logic io_read_en,
	input  logic io_write_en,
	input  io_bus_pkg::io_data_t io_write_data,
	output io_bus_pkg::io_data_t io_read_data
);

	// Bus request shared by all three blocks
	io_bus_pkg::io_req_t bus_req;

	io_bus_pkg::io_data_t perf_read_data;
	io_bus_pkg::io_data_t timer_read_data;

	assign bus_req.address = io_address;
	assign bus_req.read_en = io_read_en;
	assign bus_req.write_en = io_write_en;
	assign bus_req.write_data = io_write_data;

	performance_counters #(
		.BASE_ADDRESS(PERF_BASE),
		.NUM_EVENTS(NUM_EVENTS),
		.NUM_COUNTERS(NUM_COUNTERS)
	) i_performance_counters (
		.clk(clk),
		.reset(reset),
		.perf_events(perf_events),
		.bus_req(bus_req),
		.read_data(perf_read_data)
	);

	cycle_timer #(
		.BASE_ADDRESS(TIMER_BASE)
	) i_cycle_timer (
		.clk(clk),
		.reset(reset),
		.bus_req(bus_req),
		.read_data(timer_read_data)
	);

	// Picks the block that owns the address read in the previous cycle
	io_read_mux #(
		.PERF_BASE(PERF_BASE),
		.TIMER_BASE(TIMER_BASE),
		.NUM_COUNTERS(NUM_COUNTERS)
	) i_io_read_mux (
		.clk(clk),
		.reset(reset),
		.bus_req(bus_req),
		.perf_read_data(perf_read_data),
		.timer_read_data(timer_read_data),
		.io_read_data(io_read_data)
	);

endmodule

// ==== rtl/io_read_mux.sv ====
// ==================================================
// Read data select for the monitoring blocks
// Only word-aligned reads of mapped words return data
// Every other read returns zero in the next cycle
// ==================================================
`timescale 1ns/1ps

module io_read_mux
#(
	parameter io_bus_pkg::io_addr_t PERF_BASE = perf_pkg::PERF_BASE_DEFAULT,
	parameter io_bus_pkg::io_addr_t TIMER_BASE = perf_pkg::TIMER_BASE_DEFAULT,
	parameter int NUM_COUNTERS = 4
)
(
	input  logic clk,
	input  logic reset,

	input  io_bus_pkg::io_req_t bus_req,

	// Registered read words of the two blocks
	input  io_bus_pkg::io_data_t perf_read_data,
	input  io_bus_pkg::io_data_t timer_read_data,

	output io_bus_pkg::io_data_t io_read_data
);

	// Source codes of the window register
	localparam logic [1:0] SRC_NONE = 2'd0;
	localparam logic [1:0] SRC_PERF = 2'd1;
	localparam logic [1:0] SRC_TIMER = 2'd2;

	// Count window spans one word per counter above the selectors
	localparam io_bus_pkg::io_addr_t COUNT_LO = PERF_BASE + NUM_COUNTERS * 4;
	localparam io_bus_pkg::io_addr_t COUNT_HI = COUNT_LO + NUM_COUNTERS * 4;

	logic aligned;
	logic in_counts;
	logic in_timer;
	logic [1:0] src_next;
	logic [1:0] src_q;

	assign aligned = bus_req.address[1:0] == 2'b00;
	assign in_counts = aligned && bus_req.address >= COUNT_LO && bus_req.address < COUNT_HI;

	// The timer has the low word and the high word snapshot only
	assign in_timer = aligned
		&& (bus_req.address == TIMER_BASE || bus_req.address == TIMER_BASE + 32'd4);

	// Window decode of the current request
	// Selector addresses fall in neither window and read as zero
	always_comb
	begin
		src_next = SRC_NONE;
		if (bus_req.read_en)
		begin
			if (in_counts)
				src_next = SRC_PERF;
			else if (in_timer)
				src_next = SRC_TIMER;
		end
	end

	// Registered on the same edge as the blocks register their data
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			src_q <= SRC_NONE;
		else
			src_q <= src_next;
	end

	always_comb
	begin
		case (src_q)
			SRC_PERF: io_read_data = perf_read_data;
			SRC_TIMER: io_read_data = timer_read_data;
			default: io_read_data = '0;
		endcase
	end

endmodule

// ==== rtl/cycle_timer.sv ====
// ==================================================
// Free-running 64-bit cycle timer on the IO bus
// Read the low word first to take a consistent high word
// A write to the low word clears the count
// ==================================================
`timescale 1ns/1ps

module cycle_timer
#(
	parameter io_bus_pkg::io_addr_t BASE_ADDRESS = perf_pkg::TIMER_BASE_DEFAULT
)
(
	input  logic clk,
	input  logic reset,

	// IO bus request and registered read word
	input  io_bus_pkg::io_req_t bus_req,
	output io_bus_pkg::io_data_t read_data
);

	// Low word at the base and the high word snapshot one word above
	localparam io_bus_pkg::io_addr_t LOW_ADDR = BASE_ADDRESS;
	localparam io_bus_pkg::io_addr_t HIGH_ADDR = BASE_ADDRESS + 32'd4;

	perf_pkg::cycle_count_t cycle_count;

	// High half of the count as it was at the last low-word read
	io_bus_pkg::io_data_t high_snapshot;

	logic low_read;
	logic high_read;
	logic clear;

	// Word decode of the request
	assign low_read = bus_req.read_en && bus_req.address == LOW_ADDR;
	assign high_read = bus_req.read_en && bus_req.address == HIGH_ADDR;
	assign clear = bus_req.write_en && bus_req.address == LOW_ADDR;

	// Count every edge after reset
	// A clear forces zero at its own edge
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cycle_count <= '0;
		else if (clear)
			cycle_count <= '0;
		else
			cycle_count <= cycle_count + perf_pkg::cycle_count_t'(1);
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			read_data <= '0;
			high_snapshot <= '0;
		end
		else if (low_read)
		begin
			// Both halves come from the same pre-edge count
			read_data <= cycle_count[31:0];
			high_snapshot <= cycle_count[63:32];
		end
		else if (high_read)
		begin
			read_data <= high_snapshot;
		end
		// Any other access keeps the last word, and the mux hides it
	end

endmodule

// ==== rtl/performance_counters.sv ====
// ==================================================
// Event counters with software-written event selectors
// Events must already be synchronous to clk
// Event sources above perf_pkg::MAX_EVENTS are dropped
// Counts wrap at 2^32 without any flag
// ==================================================
`timescale 1ns/1ps

module performance_counters
#(
	parameter io_bus_pkg::io_addr_t BASE_ADDRESS = perf_pkg::PERF_BASE_DEFAULT,
	parameter int NUM_EVENTS = perf_pkg::MAX_EVENTS,
	parameter int NUM_COUNTERS = 4
)
(
	input  logic clk,
	input  logic reset,

	// One level strobe per event source
	input  logic [NUM_EVENTS-1:0] perf_events,

	// IO bus request and registered read word
	input  io_bus_pkg::io_req_t bus_req,
	output io_bus_pkg::io_data_t read_data
);

	// Counter index width
	// A single counter still needs a one-bit index
	localparam int IDX_W = (NUM_COUNTERS > 1) ? $clog2(NUM_COUNTERS) : 1;

	// Width of the padded event vector
	localparam int EVENT_W = perf_pkg::MAX_EVENTS;

	// The selectors fill the first NUM_COUNTERS words
	// The counts follow directly after them
	localparam io_bus_pkg::io_addr_t COUNT_BASE = BASE_ADDRESS + NUM_COUNTERS * 4;

	perf_pkg::counter_t event_count [NUM_COUNTERS];
	perf_pkg::event_idx_t event_select [NUM_COUNTERS];

	// Events widened to the full selector range
	logic [EVENT_W-1:0] events_wide;

	// Byte offset of the address from the count window
	io_bus_pkg::io_addr_t count_offset;

	// Word index of the count being read
	logic [IDX_W-1:0] read_idx;

	// Unused sources read as zero, so any selector value is safe to index
	assign events_wide = EVENT_W'(perf_events);

	// Word index from the bits just above the byte offset
	// Whether the address is really in the count window is decided by the read mux
	assign count_offset = bus_req.address - COUNT_BASE;
	assign read_idx = count_offset[2 +: IDX_W];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_COUNTERS; i++)
			begin
				event_count[i] <= '0;
				event_select[i] <= '0;
			end
			read_data <= '0;
		end
		else
		begin
			for (int i = 0; i < NUM_COUNTERS; i++)
			begin
				// An event high at this edge counts with the selector in use before the edge
				if (events_wide[event_select[i]])
					event_count[i] <= event_count[i] + 1'b1;

				// Selector load
				// The count itself is kept across a reselection
				if (bus_req.write_en
					&& bus_req.address == BASE_ADDRESS + io_bus_pkg::io_addr_t'(i * 4))
					event_select[i] <= perf_pkg::event_idx_t'(bus_req.write_data);
			end

			// The count is sampled on every edge, so a read sees the value before the edge
			// An index past the last counter gives zero
			if (read_idx < NUM_COUNTERS)
				read_data <= event_count[read_idx];
			else
				read_data <= '0;
		end
	end

endmodule

// ==== rtl/perf_pkg.sv ====
// ==================================================
// Types and default address map of the monitoring blocks
// At most 16 event sources can be selected by a counter
// ==================================================

package perf_pkg;

	// Number of an event source on the perf_events vector
	typedef logic [3:0] event_idx_t;

	// Upper bound on event sources
	// This is the full range of event_idx_t
	localparam int MAX_EVENTS = 16;

	// One event counter
	// It wraps silently, with no overflow flag
	typedef logic [31:0] counter_t;

	// Free-running cycle count of the timer
	// 64 bits will not wrap in any practical run
	typedef logic [63:0] cycle_count_t;

	// Default base address of the counter block
	// Selectors sit at the base and counts just above them
	localparam io_bus_pkg::io_addr_t PERF_BASE_DEFAULT = 32'h100;

	// Default base address of the cycle timer
	// The low word is at the base and the high word at base plus 4
	localparam io_bus_pkg::io_addr_t TIMER_BASE_DEFAULT = 32'h200;

endpackage

// ==== rtl/io_bus_pkg.sv ====
// ==================================================
// IO bus types shared by every bus-facing block
// The bus has plain read and write strobes with no handshake
// Addresses are byte addresses and registers are 32-bit words
// ==================================================

package io_bus_pkg;

	// Byte address as driven by the processor
	typedef logic [31:0] io_addr_t;

	// One data word on the bus
	// Reads and writes both move a whole word
	typedef logic [31:0] io_data_t;

	// Request seen by every slave in the same cycle
	// Only one of read_en and write_en is expected high at a time
	// The slaves do not check this
	typedef struct packed {
		// Target register address
		io_addr_t address;
		// Single-cycle read strobe
		// Data comes back one cycle later
		logic read_en;
		// Single-cycle write strobe
		// The write takes effect at the sampling edge
		logic write_en;
		// Write payload
		// Ignored unless write_en is high
		io_data_t write_data;
	} io_req_t;

endpackage
